/* logic/vizPkg.sv */
package vizPkg;

	// grid geometry on the 640x480 screen
	localparam int NUM_BANDS = 6;
	localparam int NUM_ROWS = 6;
	localparam int GRID_X0 = 10;
	localparam int GRID_Y0 = 10;
	localparam int COL_PITCH = 105;
	localparam int COL_WIDTH = 95;
	localparam int ROW_PITCH = 79;
	localparam int ROW_HEIGHT = 69;

	// band power to level mapping
	localparam int LEVEL_SHIFT = 8;
	localparam int DECAY_SHIFT = 4;
	// |sample| >> 5 peaks at 1024
	localparam int POWER_W = 11;

	// queue and credit sizing
	localparam int QUEUE_DEPTH = 8;
	localparam int OUT_CREDITS = 4;
	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int COUNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgbT;

	// index 0 is the top row, red at the top and green at the bottom
	localparam rgbT [NUM_ROWS-1:0] ROW_COLOUR = {
		24'h00C000, 24'h00C000,
		24'hE0E000, 24'hE0E000,
		24'hF00000, 24'hF00000
	};
	localparam rgbT PEAK_COLOUR = 24'hFFFFFF;
	localparam rgbT UNLIT_COLOUR = 24'h202020;
	localparam rgbT BG_COLOUR = 24'h000000;

	typedef struct packed {
		logic [9:0] x;
		logic [8:0] y;
	} pixCoordT;

	typedef struct packed {
		logic [2:0] band;
		logic signed [15:0] sample;
	} bandSampleT;

	typedef struct packed {
		logic [2:0] level;
		logic [2:0] peak;
	} bandStateT;

	typedef struct packed {
		pixCoordT coord;
		logic [2:0] col;
		logic [2:0] row;
		logic inBlock;
	} gridHitT;

	typedef struct packed {
		pixCoordT coord;
		logic inBlock;
		logic lit;
		logic peakMark;
		logic [2:0] row;
	} shadeT;

	typedef struct packed {
		pixCoordT coord;
		rgbT colour;
	} pixOutT;

endpackage

/* logic/bandPowerTracker.sv */
`timescale 1ns/10ps

module bandPowerTracker (
	input  logic clk,
	input  logic rstN,
	input  vizPkg::bandSampleT bandIn,
	input  logic bandValid,
	input  logic frameTick,
	output vizPkg::bandStateT [vizPkg::NUM_BANDS-1:0] bandState
);
	import vizPkg::*;

	logic [POWER_W-1:0] power [NUM_BANDS];
	logic [16:0] sampleExt;
	logic [16:0] absSample;
	logic [POWER_W-1:0] mag;
	logic [POWER_W-1:0] curPower;
	logic [POWER_W-1:0] newPower;
	logic [POWER_W-1:0] levelRaw;
	logic [2:0] newLevel;
	logic [NUM_BANDS-1:0] upd;
	logic [2:0] lvlNext [NUM_BANDS];

	always_comb begin
		// 17 bits so that -32768 rectifies cleanly
		sampleExt = {bandIn.sample[15], bandIn.sample};
		absSample = sampleExt[16] ? -sampleExt : sampleExt;
		mag = POWER_W'(absSample >> 5);
		curPower = power[bandIn.band];
		// attack instantly, decay by a fraction of itself
		if (mag >= curPower)
			newPower = mag;
		else
			newPower = curPower - (curPower >> DECAY_SHIFT);
		levelRaw = newPower >> LEVEL_SHIFT;
		newLevel = (levelRaw > POWER_W'(NUM_ROWS)) ? 3'(NUM_ROWS) : 3'(levelRaw);
		for (int b = 0; b < NUM_BANDS; b++) begin
			upd[b] = bandValid && (bandIn.band == 3'(b));
			lvlNext[b] = upd[b] ? newLevel : bandState[b].level;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int b = 0; b < NUM_BANDS; b++) begin
				power[b] <= '0;
				bandState[b] <= '0;
			end
		end else begin
			for (int b = 0; b < NUM_BANDS; b++) begin
				if (upd[b])
					power[b] <= newPower;
				bandState[b].level <= lvlNext[b];
				// frame tick drops the peak marker to the level being written
				if (frameTick)
					bandState[b].peak <= lvlNext[b];
				else if (lvlNext[b] > bandState[b].peak)
					bandState[b].peak <= lvlNext[b];
			end
		end
	end

endmodule

/* logic/gridLocator.sv */
`timescale 1ns/10ps

module gridLocator (
	input  logic clk,
	input  logic rstN,
	input  vizPkg::pixCoordT pixIn,
	input  logic pixValid,
	output vizPkg::gridHitT hit,
	output logic hitValid
);
	import vizPkg::*;

	// returns {index, inside}; index counts pitch boundaries passed
	function automatic logic [3:0] locate(input logic [9:0] rel, input int pitch,
			input int size, input int count);
		logic [2:0] idx;
		logic [9:0] offs;
		idx = '0;
		for (int k = 1; k < count; k++) begin
			if (rel >= 10'(k * pitch))
				idx = 3'(k);
		end
		offs = rel - 10'(int'(idx) * pitch);
		return {idx, (offs < 10'(size)) && (rel < 10'(count * pitch))};
	endfunction

	logic [9:0] relX;
	logic [9:0] relY;
	logic [3:0] colHit;
	logic [3:0] rowHit;
	logic pastOrigin;

	always_comb begin
		relX = pixIn.x - 10'(GRID_X0);
		relY = {1'b0, pixIn.y} - 10'(GRID_Y0);
		// left and top margins would wrap around
		pastOrigin = (pixIn.x >= 10'(GRID_X0)) && (pixIn.y >= 9'(GRID_Y0));
		colHit = locate(relX, COL_PITCH, COL_WIDTH, NUM_BANDS);
		rowHit = locate(relY, ROW_PITCH, ROW_HEIGHT, NUM_ROWS);
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			hitValid <= 1'b0;
		else
			hitValid <= pixValid;
	end

	always_ff @(posedge clk) begin
		if (pixValid) begin
			hit.coord <= pixIn;
			hit.col <= colHit[3:1];
			hit.row <= rowHit[3:1];
			hit.inBlock <= pastOrigin && colHit[0] && rowHit[0];
		end
	end

endmodule

/* logic/barShader.sv */
`timescale 1ns/10ps

module barShader (
	input  logic clk,
	input  logic rstN,
	input  vizPkg::gridHitT hit,
	input  logic hitValid,
	input  vizPkg::bandStateT [vizPkg::NUM_BANDS-1:0] bandState,
	output vizPkg::shadeT shade,
	output logic shadeValid
);
	import vizPkg::*;

	bandStateT band;
	logic [2:0] height;
	logic isLit;
	logic isPeak;

	always_comb begin
		band = bandState[hit.col];
		// rows count from the top, bars grow from the bottom
		height = 3'(NUM_ROWS - 1) - hit.row;
		isLit = hit.inBlock && (height < band.level);
		isPeak = hit.inBlock && (band.peak != '0) && (height == band.peak - 3'd1);
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			shadeValid <= 1'b0;
		else
			shadeValid <= hitValid;
	end

	always_ff @(posedge clk) begin
		if (hitValid) begin
			shade.coord <= hit.coord;
			shade.inBlock <= hit.inBlock;
			shade.lit <= isLit;
			shade.peakMark <= isPeak;
			shade.row <= hit.row;
		end
	end

endmodule

/* logic/layerMerger.sv */
`timescale 1ns/10ps

module layerMerger (
	input  logic clk,
	input  logic rstN,
	input  vizPkg::shadeT shade,
	input  logic shadeValid,
	output vizPkg::pixOutT pixel,
	output logic pixelValid
);
	import vizPkg::*;

	// bit 0 is the top layer, background always present
	logic [3:0] layer;
	logic [3:0] layerOH;
	rgbT colour;

	always_comb begin
		layer = {1'b1, shade.inBlock, shade.lit, shade.peakMark};
		// keep only the lowest set bit
		layerOH = layer & (~layer + 4'd1);
		case (layerOH)
			4'b0001: colour = PEAK_COLOUR;
			4'b0010: colour = ROW_COLOUR[shade.row];
			4'b0100: colour = UNLIT_COLOUR;
			default: colour = BG_COLOUR;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pixelValid <= 1'b0;
		else
			pixelValid <= shadeValid;
	end

	always_ff @(posedge clk) begin
		if (shadeValid) begin
			pixel.coord <= shade.coord;
			pixel.colour <= colour;
		end
	end

endmodule

/* logic/pixelCreditQueue.sv */
`timescale 1ns/10ps

module pixelCreditQueue (
	input  logic clk,
	input  logic rstN,
	input  vizPkg::pixOutT pixel,
	input  logic pixelValid,
	output vizPkg::pixOutT pixOut,
	output logic outValid,
	input  logic outCreditReturn,
	output logic pixCredit
);
	import vizPkg::*;

	pixOutT mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [COUNT_W-1:0] count;
	logic [CREDIT_W-1:0] outCredit;
	logic empty;
	logic push;
	logic popMem;

	always_comb begin
		empty = (count == '0);
		// empty queue passes the arriving pixel straight through
		outValid = (!empty || pixelValid) && (outCredit != '0);
		pixOut = empty ? pixel : mem[rdPtr];
		popMem = outValid && !empty;
		push = pixelValid && !(empty && outValid);
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			outCredit <= CREDIT_W'(OUT_CREDITS);
			pixCredit <= 1'b0;
		end else begin
			wrPtr <= wrPtr + PTR_W'(push);
			rdPtr <= rdPtr + PTR_W'(popMem);
			count <= count + COUNT_W'(push) - COUNT_W'(popMem);
			// send and return may land in the same cycle
			outCredit <= outCredit - CREDIT_W'(outValid) + CREDIT_W'(outCreditReturn);
			// one source credit back for every pixel that leaves
			pixCredit <= outValid;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr] <= pixel;
	end

endmodule

/* logic/vizTop.sv */
`timescale 1ns/10ps

module vizTop (
	input  logic clk,
	input  logic rstN,
	input  vizPkg::bandSampleT bandIn,
	input  logic bandValid,
	input  logic frameTick,
	input  vizPkg::pixCoordT pixIn,
	input  logic pixValid,
	output logic pixCredit,
	output vizPkg::pixOutT pixOut,
	output logic outValid,
	input  logic outCreditReturn
);
	import vizPkg::*;

	bandStateT [NUM_BANDS-1:0] bandState;
	gridHitT hit;
	logic hitValid;
	shadeT shade;
	logic shadeValid;
	pixOutT pixel;
	logic pixelValid;

	bandPowerTracker tracker (
		.clk(clk),
		.rstN(rstN),
		.bandIn(bandIn),
		.bandValid(bandValid),
		.frameTick(frameTick),
		.bandState(bandState)
	);

	// three-stage pixel pipeline
	gridLocator locator (
		.clk(clk),
		.rstN(rstN),
		.pixIn(pixIn),
		.pixValid(pixValid),
		.hit(hit),
		.hitValid(hitValid)
	);

	barShader shader (
		.clk(clk),
		.rstN(rstN),
		.hit(hit),
		.hitValid(hitValid),
		.bandState(bandState),
		.shade(shade),
		.shadeValid(shadeValid)
	);

	layerMerger merger (
		.clk(clk),
		.rstN(rstN),
		.shade(shade),
		.shadeValid(shadeValid),
		.pixel(pixel),
		.pixelValid(pixelValid)
	);

	pixelCreditQueue queue (
		.clk(clk),
		.rstN(rstN),
		.pixel(pixel),
		.pixelValid(pixelValid),
		.pixOut(pixOut),
		.outValid(outValid),
		.outCreditReturn(outCreditReturn),
		.pixCredit(pixCredit)
	);

endmodule

/* verification/vizTb.sv */
`timescale 1ns/10ps

module vizTb;
	import vizPkg::*;

	localparam logic [1:0] KIND_BAND = 2'd0;
	localparam logic [1:0] KIND_TICK = 2'd1;
	localparam logic [1:0] KIND_PROBE = 2'd2;

	// one row of the stimulus table
	typedef struct packed {
		logic [1:0] kind;
		logic [2:0] band;
		logic signed [15:0] sample;
		pixCoordT coord;
		rgbT colour;
		logic timed;
	} entryT;

	// scoreboard slot for a probe in flight
	typedef struct packed {
		pixCoordT coord;
		rgbT colour;
		logic timed;
		logic [31:0] acceptCycle;
	} expectT;

	logic clk;
	logic rstN;
	bandSampleT bandIn;
	logic bandValid;
	logic frameTick;
	pixCoordT pixIn;
	logic pixValid;
	logic pixCredit;
	pixOutT pixOut;
	logic outValid;
	logic outCreditReturn;

	entryT stim[$];
	expectT sb[$];
	int returnDue[$];
	int powerModel[NUM_BANDS];
	int levelModel[NUM_BANDS];
	int peakModel[NUM_BANDS];
	int cycle;
	int watchCycles;
	int timeoutLimit;
	int srcCredits;
	int outstanding;
	int sinkCredits;
	int errors;
	int checks;
	int seed;

	vizTop uut (
		.clk(clk),
		.rstN(rstN),
		.bandIn(bandIn),
		.bandValid(bandValid),
		.frameTick(frameTick),
		.pixIn(pixIn),
		.pixValid(pixValid),
		.pixCredit(pixCredit),
		.pixOut(pixOut),
		.outValid(outValid),
		.outCreditReturn(outCreditReturn)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic sampleEntry(input int band, input int sample);
		entryT e;
		e = '0;
		e.kind = KIND_BAND;
		e.band = 3'(band);
		e.sample = 16'(sample);
		stim.push_back(e);
	endtask

	task automatic tickEntry();
		entryT e;
		e = '0;
		e.kind = KIND_TICK;
		stim.push_back(e);
	endtask

	task automatic probeEntry(input int x, input int y, input rgbT colour, input logic timed);
		entryT e;
		e = '0;
		e.kind = KIND_PROBE;
		e.coord.x = 10'(x);
		e.coord.y = 9'(y);
		e.colour = colour;
		e.timed = timed;
		stim.push_back(e);
	endtask

	// band power rule applied as the sample is driven
	task automatic trackPower(input int band, input int sample);
		int mag;
		mag = (sample < 0 ? -sample : sample) >> 5;
		if (mag >= powerModel[band])
			powerModel[band] = mag;
		else
			powerModel[band] = powerModel[band] - (powerModel[band] >> DECAY_SHIFT);
		levelModel[band] = powerModel[band] >> LEVEL_SHIFT;
		if (levelModel[band] > NUM_ROWS)
			levelModel[band] = NUM_ROWS;
		if (levelModel[band] > peakModel[band])
			peakModel[band] = levelModel[band];
	endtask

	function automatic rgbT expectedColour(input int x, input int y);
		int rx;
		int ry;
		int col;
		int row;
		int height;
		rx = x - GRID_X0;
		ry = y - GRID_Y0;
		if (rx < 0 || ry < 0)
			return 24'h000000;
		col = rx / COL_PITCH;
		row = ry / ROW_PITCH;
		if (col >= NUM_BANDS || row >= NUM_ROWS || rx % COL_PITCH >= COL_WIDTH ||
				ry % ROW_PITCH >= ROW_HEIGHT)
			return 24'h000000;
		height = NUM_ROWS - 1 - row;
		if (peakModel[col] != 0 && height == peakModel[col] - 1)
			return 24'hFFFFFF;
		if (height < levelModel[col])
			return row < 2 ? 24'hF00000 : (row < 4 ? 24'hE0E000 : 24'h00C000);
		return 24'h202020;
	endfunction

	// one clock of output sampling, credit bookkeeping and default drives
	task automatic nextCycle();
		expectT e;
		int delay;
		@(posedge clk);
		cycle++;
		if (pixCredit) begin
			srcCredits++;
			if (srcCredits > QUEUE_DEPTH) begin
				errors++;
				$display("source credit overflow at %0t, more credits back than pixels sent", $time);
			end
		end
		if (outValid) begin
			// pixel has left the DUT
			outstanding--;
			if (sinkCredits == 0) begin
				errors++;
				$display("FAIL at %0t: outValid asserted with no sink credit left", $time);
			end else
				sinkCredits--;
			// sink hands the credit back 0 to 5 cycles later
			delay = {$random(seed)} % 6;
			returnDue.push_back(cycle + delay);
			if (sb.size() == 0) begin
				errors++;
				$display("FAIL at %0t: output pixel with no probe outstanding", $time);
			end else begin
				e = sb.pop_front();
				checks++;
				if (pixOut.coord != e.coord || pixOut.colour != e.colour) begin
					errors++;
					$display("FAIL at %0t: got (%0d,%0d) %h, expected (%0d,%0d) %h", $time,
						pixOut.coord.x, pixOut.coord.y, pixOut.colour,
						e.coord.x, e.coord.y, e.colour);
				end
				if (e.timed && cycle - int'(e.acceptCycle) != 3) begin
					errors++;
					$display("FAIL at %0t: latency %0d cycles, expected 3", $time,
						cycle - int'(e.acceptCycle));
				end
			end
		end
		if (outCreditReturn)
			sinkCredits++;
		bandValid <= 1'b0;
		frameTick <= 1'b0;
		pixValid <= 1'b0;
		if (returnDue.size() > 0 && returnDue[0] <= cycle) begin
			void'(returnDue.pop_front());
			outCreditReturn <= 1'b1;
		end else
			outCreditReturn <= 1'b0;
	endtask

	task automatic applyEntry(input entryT s);
		expectT e;
		nextCycle();
		case (s.kind)
			KIND_BAND: begin
				bandIn.band <= s.band;
				bandIn.sample <= s.sample;
				bandValid <= 1'b1;
				trackPower(int'(s.band), int'(s.sample));
			end
			KIND_TICK: begin
				frameTick <= 1'b1;
				for (int b = 0; b < NUM_BANDS; b++)
					peakModel[b] = levelModel[b];
			end
			default: begin
				// timed probes start from an empty queue with a sink credit
				while (s.timed && (sb.size() > 0 || sinkCredits == 0))
					nextCycle();
				while (srcCredits == 0)
					nextCycle();
				if (outstanding >= QUEUE_DEPTH) begin
					errors++;
					$display("source would exceed %0d pixels in flight at %0t, credits came back early",
						QUEUE_DEPTH, $time);
				end
				pixIn <= s.coord;
				pixValid <= 1'b1;
				srcCredits--;
				outstanding++;
				e.coord = s.coord;
				e.colour = expectedColour(int'(s.coord.x), int'(s.coord.y));
				e.timed = s.timed;
				e.acceptCycle = 32'(cycle + 1);
				if (e.colour != s.colour) begin
					errors++;
					$display("FAIL at %0t: model gives %h for (%0d,%0d), table has %h",
						$time, e.colour, s.coord.x, s.coord.y, s.colour);
				end
				sb.push_back(e);
			end
		endcase
	endtask

	task automatic buildTable();
		// nothing lit after reset so blocks are grey and gaps black
		probeEntry(57, 44, 24'h202020, 1'b0);
		probeEntry(582, 439, 24'h202020, 1'b0);
		probeEntry(104, 78, 24'h202020, 1'b0);
		probeEntry(105, 78, 24'h000000, 1'b0);
		probeEntry(110, 44, 24'h000000, 1'b0);
		probeEntry(267, 84, 24'h000000, 1'b0);
		probeEntry(5, 5, 24'h000000, 1'b0);
		probeEntry(635, 300, 24'h000000, 1'b0);
		probeEntry(267, 476, 24'h000000, 1'b0);
		// full scale on band 2 gives level and peak 4
		sampleEntry(2, -32768);
		probeEntry(267, 439, 24'h00C000, 1'b0);
		probeEntry(267, 360, 24'h00C000, 1'b0);
		probeEntry(267, 281, 24'hE0E000, 1'b0);
		probeEntry(267, 202, 24'hFFFFFF, 1'b0);
		probeEntry(267, 123, 24'h202020, 1'b0);
		probeEntry(267, 44, 24'h202020, 1'b0);
		probeEntry(372, 439, 24'h202020, 1'b0);
		probeEntry(162, 439, 24'h202020, 1'b0);
		// five small samples decay band 2 to level 2
		for (int i = 0; i < 5; i++)
			sampleEntry(2, 1000);
		probeEntry(267, 202, 24'hFFFFFF, 1'b0);
		probeEntry(267, 281, 24'h202020, 1'b0);
		probeEntry(267, 360, 24'h00C000, 1'b0);
		tickEntry();
		probeEntry(267, 360, 24'hFFFFFF, 1'b0);
		probeEntry(267, 439, 24'h00C000, 1'b0);
		probeEntry(267, 202, 24'h202020, 1'b0);
		// burst against the slow sink
		sampleEntry(0, 12000);
		sampleEntry(5, -20000);
		probeEntry(57, 439, 24'hFFFFFF, 1'b0);
		probeEntry(57, 360, 24'h202020, 1'b0);
		probeEntry(582, 439, 24'h00C000, 1'b0);
		probeEntry(582, 360, 24'hFFFFFF, 1'b0);
		probeEntry(582, 281, 24'h202020, 1'b0);
		probeEntry(267, 439, 24'h00C000, 1'b0);
		probeEntry(267, 360, 24'hFFFFFF, 1'b0);
		probeEntry(372, 281, 24'h202020, 1'b0);
		probeEntry(477, 80, 24'h000000, 1'b0);
		probeEntry(10, 10, 24'h202020, 1'b0);
		probeEntry(629, 473, 24'h00C000, 1'b0);
		probeEntry(630, 473, 24'h000000, 1'b0);
		probeEntry(477, 44, 24'h202020, 1'b0);
		probeEntry(162, 202, 24'h202020, 1'b0);
		// single probes through an idle path
		probeEntry(582, 439, 24'h00C000, 1'b1);
		probeEntry(5, 5, 24'h000000, 1'b1);
	endtask

	// watchdog sized from the table length
	always @(posedge clk) begin
		watchCycles++;
		if (watchCycles > timeoutLimit) begin
			$display("timeout: run hung after %0d cycles with %0d probes unanswered",
				watchCycles, sb.size());
			$display("checks %0d, errors %0d", checks, errors);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		rstN = 1'b0;
		bandIn = '0;
		bandValid = 1'b0;
		frameTick = 1'b0;
		pixIn = '0;
		pixValid = 1'b0;
		outCreditReturn = 1'b0;
		seed = 32'h740a12a7;
		cycle = 0;
		watchCycles = 0;
		srcCredits = QUEUE_DEPTH;
		outstanding = 0;
		sinkCredits = OUT_CREDITS;
		errors = 0;
		checks = 0;
		buildTable();
		timeoutLimit = stim.size() * 20 + 200;
		repeat (8) @(posedge clk);
		rstN <= 1'b1;
		for (int i = 0; i < stim.size(); i++)
			applyEntry(stim[i]);
		while (sb.size() > 0)
			nextCycle();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* build.f */
logic/vizPkg.sv
logic/bandPowerTracker.sv
logic/gridLocator.sv
logic/barShader.sv
logic/layerMerger.sv
logic/pixelCreditQueue.sv
logic/vizTop.sv
verification/vizTb.sv

/* run.sh */
#!/bin/sh
# compiles the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module vizTb -o vizSim
./obj_dir/vizSim > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
	echo "simulation ended without a verdict"
	exit 1
fi
echo "simulation passed"
